//--- logic/adc_capture_pkg.sv
package adc_capture_pkg;

   // width of the period counter, the bit counter and the decimation counter
   // six bits cover periods and words of up to 64 ticks or bits
   localparam int count_width = 6;

   // the capture FIFO write port is always one 32-bit word wide
   localparam int capture_width = 32;

   // phase of one conversion period as stepped by the sequencer
   // the pins follow this phase one tick later because they are registered
   typedef enum logic [2:0] {
      // held here while external reset is high and for one tick after
      state_reset,
      // first tick of MCLK high
      state_start,
      // the rest of the MCLK high window
      state_convert,
      // one bit slot that may carry the SYNC pulse
      state_sync,
      // SCKA toggles here to clock out the distributed read bits
      state_acquire,
      // idle until the period counter wraps
      state_wait
   } cycle_state_t;

   // progress through the outer word, which spans adc_decimate periods
   typedef enum logic [1:0] {
      // bits are still being read for the current word
      mode_acquire,
      // the word is complete, so only MCLK keeps running
      mode_wait,
      // a new word starts, so SYNC is sent and the first SCKA pulse is held back
      mode_sync
   } word_mode_t;

   // the MSB of each new word is already on SDOA when SYNC falls, which
   // is why the SYNC slot counts as a shift in the word tracker.

endpackage

//--- logic/acquire_phase_if.sv
`timescale 1ns/1ps

interface acquire_phase_if import adc_capture_pkg::*; ();

   // current phase of the conversion period
   cycle_state_t phase;

   // copies of the registered SCKA and SYNC pins as the ADCs see them
   logic scka;
   logic sync;

   // high for the single start tick of each period
   logic period_start;

   // outer word mode, which decides whether sync and acquire are skipped
   word_mode_t mode;

   // the sequencer owns the period timing and only reads back the word mode
   modport sequencer (
      output phase, scka, sync, period_start,
      input  mode
   );

   // the tracker follows the timing and owns the word mode
   modport tracker (
      input  phase, scka, sync, period_start,
      output mode
   );

endinterface

//--- logic/conversion_sequencer.sv
`timescale 1ns/1ps

module conversion_sequencer import adc_capture_pkg::*; #(
   parameter int convert_cycles = 6,
   parameter int adc_cycles     = 20,
   parameter int acquire_nbits  = 4
) (
   input  logic capture_clk,
   input  logic external_reset,
   output logic adc_mclk,
   output logic adc_scka,
   output logic adc_sync,
   acquire_phase_if.sequencer phase_bus
);

   // tick positions in the period where the phase machine moves on
   localparam logic [count_width-1:0] convert_last = count_width'(convert_cycles - 1);
   localparam logic [count_width-1:0] sync_last    = count_width'(convert_cycles + 1);
   localparam logic [count_width-1:0] acquire_last =
      count_width'(convert_cycles + 1 + 2 * acquire_nbits);
   localparam logic [count_width-1:0] period_last  = count_width'(adc_cycles - 1);

   cycle_state_t state;
   logic [count_width-1:0] adc_cycle;
   logic scka_positive;

   // the period counter runs freely and wraps every adc_cycles ticks
   always_ff @(posedge capture_clk) begin
      if (external_reset || state == state_reset || adc_cycle == period_last) begin
         adc_cycle <= '0;
      end else begin
         adc_cycle <= adc_cycle + 1'b1;
      end
   end

   // SCKA rises on the tick after an even count, so each bit takes two ticks
   assign scka_positive = ~adc_cycle[0];

   // the phase machine only follows the counter and the word mode
   always_ff @(posedge capture_clk) begin
      if (external_reset) begin
         state <= state_reset;
      end else begin
         case (state)
            // reset drops into wait so the first start lands on a counter wrap
            state_reset: state <= state_wait;
            state_start: state <= state_convert;
            state_convert: begin
               // a finished word needs no sync slot and no bits
               if (adc_cycle == convert_last) begin
                  state <= (phase_bus.mode == mode_wait) ? state_wait : state_sync;
               end
            end
            state_sync: begin
               if (adc_cycle == sync_last) begin
                  state <= state_acquire;
               end
            end
            state_acquire: begin
               // with no idle ticks left the next period starts at once
               if (adc_cycle == acquire_last) begin
                  state <= (adc_cycle == period_last) ? state_start : state_wait;
               end
            end
            state_wait: begin
               if (adc_cycle == period_last) begin
                  state <= state_start;
               end
            end
            default: state <= state_reset;
         endcase
      end
   end

   // the ADC pins are registered so no runt pulse can reach them
   always_ff @(posedge capture_clk) begin
      if (external_reset) begin
         adc_mclk <= 1'b0;
         adc_scka <= 1'b0;
         adc_sync <= 1'b1;
      end else begin
         adc_mclk <= (state == state_start) || (state == state_convert);
         // in sync mode the MSB is already on SDOA, so the first pulse is held back
         adc_scka <= (state == state_acquire && phase_bus.mode != mode_sync) ?
                     scka_positive : 1'b0;
         // the falling SYNC edge restarts the decimation filter in every ADC
         adc_sync <= (state == state_reset) ||
                     (state == state_sync && phase_bus.mode == mode_sync && scka_positive);
      end
   end

   assign phase_bus.phase        = state;
   assign phase_bus.scka         = adc_scka;
   assign phase_bus.sync         = adc_sync;
   assign phase_bus.period_start = (state == state_start);

   // the bus must be quiet while the ADC converts
   a_mclk_quiet_in_acquire: assert property (
      @(posedge capture_clk) disable iff (external_reset)
      (state == state_acquire) |-> !adc_mclk
   );

   a_phase_legal: assert property (
      @(posedge capture_clk) disable iff (external_reset)
      state inside {state_reset, state_start, state_convert,
                    state_sync, state_acquire, state_wait}
   );

endmodule

//--- logic/word_tracker.sv
`timescale 1ns/1ps

module word_tracker import adc_capture_pkg::*; #(
   parameter int adc_bits     = 24,
   parameter int adc_decimate = 8
) (
   input  logic capture_clk,
   input  logic external_reset,
   acquire_phase_if.tracker phase_bus,
   output logic shift,
   output logic load
);

   localparam logic [count_width-1:0] decimate_top = count_width'(adc_decimate - 1);
   localparam logic [count_width-1:0] bit_top      = count_width'(adc_bits - 1);

   logic [count_width-1:0] decimate_counter;
   logic [count_width-1:0] acquire_bit;
   logic word_wrap;
   logic [1:0] load_count;
   logic wrapped_once;

   // a high SCKA or SYNC pin means the ADC shifts on the next falling edge
   // so the bit on SDOA has to be taken now
   assign shift = phase_bus.scka || phase_bus.sync;

   // a new word begins at a period start once the decimation count has run out
   assign word_wrap = phase_bus.period_start && (decimate_counter == '0);

   // the counter starts at zero so the first start after reset opens a word
   always_ff @(posedge capture_clk) begin
      if (external_reset) begin
         decimate_counter <= '0;
         phase_bus.mode   <= mode_sync;
      end else if (phase_bus.period_start) begin
         if (decimate_counter == '0) begin
            decimate_counter <= decimate_top;
            phase_bus.mode   <= mode_sync;
         end else begin
            decimate_counter <= decimate_counter - 1'b1;
            // load may fall on a start tick when the period has no idle ticks
            if (load) begin
               phase_bus.mode <= mode_wait;
            end
         end
      end else if (load) begin
         phase_bus.mode <= mode_wait;
      end else if (phase_bus.phase == state_acquire && phase_bus.mode == mode_sync) begin
         // sync mode lasts up to the first acquire tick, long enough to hold back one SCKA
         phase_bus.mode <= mode_acquire;
      end
   end

   // the bit counter is held while the decimation count is zero, which keeps
   // it aligned with the word and clears any shift seen before the first word
   always_ff @(posedge capture_clk) begin
      if (external_reset || decimate_counter == '0) begin
         acquire_bit <= bit_top;
         load        <= 1'b0;
      end else if (shift && acquire_bit == '0) begin
         acquire_bit <= bit_top;
         load        <= 1'b1;
      end else begin
         acquire_bit <= shift ? acquire_bit - 1'b1 : acquire_bit;
         load        <= 1'b0;
      end
   end

   // loads seen since the last word wrap, saturating at three
   always_ff @(posedge capture_clk) begin
      if (external_reset) begin
         load_count   <= '0;
         wrapped_once <= 1'b0;
      end else if (word_wrap) begin
         load_count   <= '0;
         wrapped_once <= 1'b1;
      end else if (load && load_count != 2'd3) begin
         load_count <= load_count + 1'b1;
      end
   end

   a_one_load_per_word: assert property (
      @(posedge capture_clk) disable iff (external_reset)
      (word_wrap && wrapped_once) |-> (load_count == 2'd1)
   );

endmodule

//--- logic/channel_shift_register.sv
`timescale 1ns/1ps

module channel_shift_register #(
   parameter int adc_bits = 24
) (
   input  logic              capture_clk,
   input  logic              external_reset,
   input  logic              sdo,
   input  logic              shift,
   input  logic              load,
   input  logic [adc_bits:0] chain_in,
   output logic [adc_bits:0] chain_out
);

   logic [adc_bits-1:0] shift_reg;

   // the ADC sends MSB first, so new bits enter at the bottom
   always_ff @(posedge capture_clk) begin
      if (shift) begin
         shift_reg <= {shift_reg[adc_bits-2:0], sdo};
      end
   end

   // the chain stage holds a valid flag above the word
   // while it unloads, the shifter is already collecting the next word
   always_ff @(posedge capture_clk) begin
      if (external_reset) begin
         chain_out <= '0;
      end else if (load) begin
         chain_out <= {1'b1, shift_reg};
      end else begin
         chain_out <= chain_in;
      end
   end

endmodule

//--- logic/sample_chain.sv
`timescale 1ns/1ps

module sample_chain import adc_capture_pkg::*; #(
   parameter int adc_channels = 4,
   parameter int adc_bits     = 24
) (
   input  logic                     capture_clk,
   input  logic                     external_reset,
   input  logic [adc_channels-1:0]  adc_sdoa,
   input  logic                     shift,
   input  logic                     load,
   input  logic                     capture_full,
   output logic [capture_width-1:0] capture_data,
   output logic                     capture_en
);

   // stage c feeds stage c-1, and stage 0 feeds the FIFO port
   logic [adc_bits:0] chain [adc_channels+1];

   // zeros flow in at the far end so each stage empties after unloading
   assign chain[adc_channels] = '0;

   // all channels load at once and then leave one per cycle, channel 0 first
   for (genvar c = 0; c < adc_channels; c++) begin : g_channel
      channel_shift_register #(
         .adc_bits(adc_bits)
      ) i_channel (
         .capture_clk   (capture_clk),
         .external_reset(external_reset),
         .sdo           (adc_sdoa[c]),
         .shift         (shift),
         .load          (load),
         .chain_in      (chain[c+1]),
         .chain_out     (chain[c])
      );
   end

   // the word is left justified so its MSB always sits in bit 31
   always_ff @(posedge capture_clk) begin
      capture_data <= capture_width'(chain[0][adc_bits-1:0]) << (capture_width - adc_bits);
   end

   // a valid word that meets a full FIFO is lost, and nothing upstream stalls
   always_ff @(posedge capture_clk) begin
      if (external_reset) begin
         capture_en <= 1'b0;
      end else begin
         capture_en <= chain[0][adc_bits] && !capture_full;
      end
   end

   // a new load would overwrite words that are still leaving the chain
   a_no_load_while_unloading: assert property (
      @(posedge capture_clk) disable iff (external_reset)
      load |-> !chain[0][adc_bits]
   );

endmodule

//--- logic/multi_adc_capture.sv
`timescale 1ns/1ps

module multi_adc_capture import adc_capture_pkg::*; #(
   parameter int adc_channels   = 4,
   parameter int adc_bits       = 24,
   parameter int adc_decimate   = 8,
   parameter int convert_cycles = 6,
   parameter int adc_cycles     = 20,
   parameter int acquire_nbits  = 4
) (
   input  logic                     capture_clk,
   input  logic                     external_reset,
   input  logic [adc_channels-1:0]  adc_sdoa,
   input  logic                     capture_full,
   output logic                     adc_mclk,
   output logic                     adc_scka,
   output logic                     adc_sync,
   output logic [capture_width-1:0] capture_data,
   output logic                     capture_en
);

   logic shift;
   logic load;

   // period timing and word progress meet on this bus
   acquire_phase_if phase_bus ();

   conversion_sequencer #(
      .convert_cycles(convert_cycles),
      .adc_cycles    (adc_cycles),
      .acquire_nbits (acquire_nbits)
   ) i_sequencer (
      .capture_clk   (capture_clk),
      .external_reset(external_reset),
      .adc_mclk      (adc_mclk),
      .adc_scka      (adc_scka),
      .adc_sync      (adc_sync),
      .phase_bus     (phase_bus.sequencer)
   );

   word_tracker #(
      .adc_bits    (adc_bits),
      .adc_decimate(adc_decimate)
   ) i_tracker (
      .capture_clk   (capture_clk),
      .external_reset(external_reset),
      .phase_bus     (phase_bus.tracker),
      .shift         (shift),
      .load          (load)
   );

   // one shifter per ADC, all driven by the same shift and load strobes
   sample_chain #(
      .adc_channels(adc_channels),
      .adc_bits    (adc_bits)
   ) i_chain (
      .capture_clk   (capture_clk),
      .external_reset(external_reset),
      .adc_sdoa      (adc_sdoa),
      .shift         (shift),
      .load          (load),
      .capture_full  (capture_full),
      .capture_data  (capture_data),
      .capture_en    (capture_en)
   );

endmodule

//--- verification/adc_serial_model.sv
`timescale 1ns/1ps

module adc_serial_model #(
   parameter int adc_channels = 4,
   parameter int adc_bits     = 24
) (
   input  logic                             capture_clk,
   input  logic                             external_reset,
   input  logic                             adc_sync,
   input  logic                             adc_scka,
   output logic [adc_channels-1:0]          sdoa,
   output logic [adc_channels*adc_bits-1:0] drawn_words,
   output logic                             word_taken
);

   integer seed = 32'ha007fbfb;
   int bit_pos = 0;
   logic word_open = 1'b0;
   // SYNC is held high through reset, so the first edge seen is never a rise
   logic sync_seen = 1'b1;
   logic scka_seen = 1'b0;

   initial begin
      sdoa        = '0;
      drawn_words = '0;
      word_taken  = 1'b0;
   end

   // the pins are watched on the falling clock edge, half a tick from the sampling edge
   always @(negedge capture_clk) begin : adc_step
      int c;
      word_taken = 1'b0;
      if (external_reset) begin
         word_open = 1'b0;
      end else if (adc_sync && !sync_seen) begin
         // a rising SYNC opens a new word and puts its MSB on SDOA at once
         for (c = 0; c < adc_channels; c++) begin
            drawn_words[c*adc_bits +: adc_bits] = adc_bits'($random(seed));
         end
         bit_pos   = adc_bits - 1;
         word_open = 1'b1;
      end else if (word_open && ((sync_seen && !adc_sync) || (scka_seen && !adc_scka))) begin
         // a falling SYNC or SCKA means the DUT has just taken the current bit
         if (bit_pos == 0) begin
            word_open  = 1'b0;
            word_taken = 1'b1;
         end else begin
            bit_pos = bit_pos - 1;
         end
      end
      // SDOA idles low between words
      for (c = 0; c < adc_channels; c++) begin
         sdoa[c] = word_open && drawn_words[c*adc_bits + bit_pos];
      end
      sync_seen = adc_sync;
      scka_seen = adc_scka;
   end

endmodule

//--- verification/multi_adc_capture_tb.sv
`timescale 1ns/1ps

module multi_adc_capture_tb;

   // the DUT runs with its defaults, repeated here to derive the expected timing
   localparam int adc_channels   = 4;
   localparam int adc_bits       = 24;
   localparam int adc_decimate   = 8;
   localparam int convert_cycles = 6;
   localparam int adc_cycles     = 20;
   // enough words that every channel meets a free FIFO slot more than once
   localparam int words_to_run   = 12;
   // one word takes adc_decimate periods, so three words' worth is a generous limit
   localparam int word_timeout   = 3 * adc_decimate * adc_cycles;

   logic                             capture_clk;
   logic                             external_reset;
   logic [adc_channels-1:0]          adc_sdoa;
   logic                             capture_full;
   logic                             adc_mclk;
   logic                             adc_scka;
   logic                             adc_sync;
   logic [31:0]                      capture_data;
   logic                             capture_en;
   logic [adc_channels*adc_bits-1:0] drawn_words;
   logic                             word_taken;

   integer seed = 32'ha007fbfb;
   int error_count = 0;
   logic timed_out = 1'b0;
   int words_seen;
   logic [adc_bits-1:0] expected_queue [$];
   int slot_left;
   int slot_channel;
   int exp_channel;
   logic exp_en;
   logic [31:0] exp_data;
   int written [adc_channels];
   logic mclk_prev;
   logic sync_prev;
   int mclk_run;
   int since_rise;
   logic rise_seen;
   int rises_since_sync;
   logic sync_rise_seen;

   multi_adc_capture #(
      .adc_channels  (adc_channels),
      .adc_bits      (adc_bits),
      .adc_decimate  (adc_decimate),
      .convert_cycles(convert_cycles),
      .adc_cycles    (adc_cycles)
   ) i_dut (
      .capture_clk   (capture_clk),
      .external_reset(external_reset),
      .adc_sdoa      (adc_sdoa),
      .capture_full  (capture_full),
      .adc_mclk      (adc_mclk),
      .adc_scka      (adc_scka),
      .adc_sync      (adc_sync),
      .capture_data  (capture_data),
      .capture_en    (capture_en)
   );

   adc_serial_model #(
      .adc_channels(adc_channels),
      .adc_bits    (adc_bits)
   ) i_model (
      .capture_clk   (capture_clk),
      .external_reset(external_reset),
      .adc_sync      (adc_sync),
      .adc_scka      (adc_scka),
      .sdoa          (adc_sdoa),
      .drawn_words   (drawn_words),
      .word_taken    (word_taken)
   );

   initial begin
      capture_clk = 1'b0;
      forever #20 capture_clk = ~capture_clk;
   end

   task automatic note_mismatch(input string what);
      error_count++;
      $display("ERR %0t: %s", $time, what);
   endtask

   // the FIFO reports full about a quarter of the time
   always @(negedge capture_clk) begin
      capture_full = (($random(seed) & 3) == 0);
   end

   // run lengths of MCLK and the spacing of its rising edges and of SYNC
   always @(posedge capture_clk) begin : track_pins
      if (external_reset) begin
         mclk_prev        <= 1'b0;
         sync_prev        <= 1'b1;
         mclk_run         <= 0;
         since_rise       <= 0;
         rise_seen        <= 1'b0;
         rises_since_sync <= 0;
         sync_rise_seen   <= 1'b0;
      end else begin
         mclk_prev <= adc_mclk;
         sync_prev <= adc_sync;
         mclk_run  <= adc_mclk ? mclk_run + 1 : 0;
         if (adc_mclk && !mclk_prev) begin
            since_rise       <= 1;
            rise_seen        <= 1'b1;
            rises_since_sync <= rises_since_sync + 1;
         end else begin
            since_rise <= since_rise + 1;
         end
         // SYNC sits mid period, so it never shares a tick with an MCLK rise
         if (adc_sync && !sync_prev) begin
            rises_since_sync <= 0;
            sync_rise_seen   <= 1'b1;
         end
      end
   end

   // after a load the channels leave the chain one per cycle, channel 0 first,
   // and each is written or lost depending on capture_full in its own cycle
   always @(posedge capture_clk) begin : follow_unload
      int c;
      logic [adc_bits-1:0] word;
      if (external_reset) begin
         slot_left    <= 0;
         slot_channel <= 0;
         exp_channel  <= 0;
         exp_en       <= 1'b0;
         exp_data     <= '0;
         words_seen   <= 0;
      end else begin
         exp_en <= 1'b0;
         if (slot_left != 0) begin
            word = '0;
            if (expected_queue.size() == 0) begin
               error_count++;
               $display("a word left the chain at %0t with nothing queued by the model", $time);
            end else begin
               word = expected_queue.pop_front();
            end
            exp_en       <= !capture_full;
            exp_data     <= {word, {(32 - adc_bits){1'b0}}};
            exp_channel  <= slot_channel;
            slot_channel <= (slot_channel + 1) % adc_channels;
            slot_left    <= slot_left - 1;
         end
         if (word_taken) begin
            // the last bit went in on the previous edge, so the chain loads on this one
            for (c = 0; c < adc_channels; c++) begin
               expected_queue.push_back(drawn_words[c*adc_bits +: adc_bits]);
            end
            slot_left  <= adc_channels;
            words_seen <= words_seen + 1;
         end
      end
   end

   always @(posedge capture_clk) begin : count_writes
      if (external_reset) begin
         written <= '{default: 0};
      end else if (capture_en) begin
         written[exp_channel] <= written[exp_channel] + 1;
      end
   end

   a_reset_values: assert property (@(posedge capture_clk)
      external_reset |=> (!adc_mclk && !adc_scka && !capture_en && adc_sync))
      else note_mismatch("pins left their reset values while reset was held");

   a_mclk_width: assert property (@(posedge capture_clk) disable iff (external_reset)
      (mclk_prev && !adc_mclk) |-> (mclk_run == convert_cycles))
      else note_mismatch($sformatf("MCLK was high for %0d ticks", $sampled(mclk_run)));

   a_mclk_period: assert property (@(posedge capture_clk) disable iff (external_reset)
      (adc_mclk && !mclk_prev && rise_seen) |-> (since_rise == adc_cycles))
      else note_mismatch($sformatf("MCLK rose %0d ticks after the last rise",
                                   $sampled(since_rise)));

   a_sync_rate: assert property (@(posedge capture_clk) disable iff (external_reset)
      (adc_sync && !sync_prev && sync_rise_seen) |-> (rises_since_sync == adc_decimate))
      else note_mismatch($sformatf("SYNC came after %0d MCLK periods",
                                   $sampled(rises_since_sync)));

   a_sync_width: assert property (@(posedge capture_clk) disable iff (external_reset)
      (adc_sync && !sync_prev) |=> !adc_sync)
      else note_mismatch("SYNC stayed high for more than one tick");

   a_write_enable: assert property (@(posedge capture_clk) disable iff (external_reset)
      capture_en == exp_en)
      else note_mismatch($sformatf("capture_en is %b, expected %b",
                                   $sampled(capture_en), $sampled(exp_en)));

   a_write_data: assert property (@(posedge capture_clk) disable iff (external_reset)
      exp_en |-> (capture_data == exp_data))
      else note_mismatch($sformatf("capture_data is %h, expected %h",
                                   $sampled(capture_data), $sampled(exp_data)));

   a_zero_fill: assert property (@(posedge capture_clk) disable iff (external_reset)
      capture_en |-> (capture_data[31-adc_bits:0] == '0))
      else note_mismatch("low bits of capture_data are not zero");

   a_drop_when_full: assert property (@(posedge capture_clk) disable iff (external_reset)
      capture_full |=> !capture_en)
      else note_mismatch("capture_en was high one cycle after capture_full");

   initial begin : run_test
      int waited;
      int target;
      int c;
      external_reset = 1'b1;
      capture_full   = 1'b0;
      repeat (16) @(posedge capture_clk);
      @(negedge capture_clk);
      external_reset = 1'b0;
      for (target = 1; target <= words_to_run && !timed_out; target++) begin
         waited = 0;
         while (words_seen < target && waited < word_timeout) begin
            @(posedge capture_clk);
            waited++;
         end
         if (words_seen < target) begin
            timed_out = 1'b1;
            $display("no word %0d came from the ADCs within %0d cycles", target, waited);
         end
      end
      // the last word still has to leave the chain and meet its checks
      waited = 0;
      while (!timed_out && slot_left != 0 && waited < 4 * adc_channels) begin
         @(posedge capture_clk);
         waited++;
      end
      if (slot_left != 0) begin
         timed_out = 1'b1;
         $display("the chain did not unload the last word in time");
      end
      repeat (2) @(posedge capture_clk);
      for (c = 0; c < adc_channels; c++) begin
         a_channel_written: assert (written[c] > 0) else begin
            error_count++;
            $display("channel %0d never reached the FIFO", c);
         end
      end
      $display("errors %0d, timeouts %0d, words %0d", error_count, timed_out, words_seen);
      if (error_count == 0 && !timed_out) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- filelist.f
logic/adc_capture_pkg.sv
logic/acquire_phase_if.sv
logic/conversion_sequencer.sv
logic/word_tracker.sv
logic/channel_shift_register.sv
logic/sample_chain.sv
logic/multi_adc_capture.sv
verification/adc_serial_model.sv
verification/multi_adc_capture_tb.sv

//--- Makefile
# build and run the capture testbench with Verilator

LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator, run it and check the log"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	rm -f $(LOG)
	verilator --binary --assert --timing --timescale 1ns/1ps -Wno-fatal \
		--top-module multi_adc_capture_tb -f filelist.f -Mdir obj_dir -o sim
	-./obj_dir/sim > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "all tests passed" $(LOG) || (echo "simulation FAILED"; exit 1)
	@echo "simulation PASSED"

clean:
	rm -rf obj_dir $(LOG)
